// ==== build.f ====
+incdir+verilog
verilog/dnc_pkg.sv
verilog/dnc_matrix_transpose.sv
verilog/dnc_matrix_product.sv
verilog/dnc_backward_weighting.sv
verif/tb_dnc_backward_weighting.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the backward weighting testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing \
  -f build.f \
  --top-module tb_dnc_backward_weighting \
  --Mdir obj_dir \
  -o tb_sim

./obj_dir/tb_sim > "$LOG" 2>&1
cat "$LOG"

if grep -q "=== FAIL ===" "$LOG"; then
  echo "Simulation reported failure, see $LOG"
  exit 1
fi

echo "Simulation finished without failure"

// ==== verif/tb_dnc_backward_weighting.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dnc_defines.svh"

module tb_dnc_backward_weighting;

  import dnc_pkg::*;

  localparam int          CLK_PERIOD = 20;
  localparam logic [31:0] LFSR_SEED  = 32'h7c1f0e1c;
  // Reference data fill modes
  localparam int FILL_IDENT = 0;
  localparam int FILL_RAND  = 1;
  localparam int FILL_MAX   = 2;

  // Cycles of one run for the L load plus R heads of N loads and N x (N+1) compute
  function automatic int run_cycles(input int n, input int r);
    return n * n + r * n * (n + 2);
  endfunction

  localparam int WORK_CYCLES = run_cycles(4, 2) + run_cycles(5, 3) + run_cycles(8, 4) +
                               run_cycles(3, 1) + run_cycles(3, 2) + run_cycles(6, 1);
  // Gapped strobes stretch the loads of the noisy run
  localparam int TIMEOUT_CYCLES = 2 * WORK_CYCLES + 500;

  logic        CLK;
  logic        RST;
  logic        start;
  dnc_size_t   size;
  dnc_value_t  l_in;
  logic        l_in_valid;
  dnc_value_t  w_in;
  logic        w_in_valid;
  logic        busy;
  logic        done;
  logic        l_accept;
  logic        w_accept;
  dnc_b_elem_t b_out;
  logic        b_out_valid;

  logic [31:0] lfsr;
  int          errors;
  int          n_checks;
  int          n_done;
  int          elems_at_done;
  dnc_b_elem_t got_q [$];

  // Reference copies of L(g;j) and w(i;g)
  dnc_value_t link_m   [`DNC_MAX_N][`DNC_MAX_N];
  dnc_value_t weight_m [`DNC_MAX_R][`DNC_MAX_N];

  dnc_backward_weighting u_dut (
    .CLK         (CLK),
    .RST         (RST),
    .start       (start),
    .size        (size),
    .l_in        (l_in),
    .l_in_valid  (l_in_valid),
    .w_in        (w_in),
    .w_in_valid  (w_in_valid),
    .busy        (busy),
    .done        (done),
    .l_accept    (l_accept),
    .w_accept    (w_accept),
    .b_out       (b_out),
    .b_out_valid (b_out_valid)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("Timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
    $display("=== FAIL ===");
    $finish;
  end

  // Output collector samples mid-cycle where outputs are settled
  always @(negedge CLK) begin
    if (b_out_valid) begin
      got_q.push_back(b_out);
    end
    if (done) begin
      n_done++;
      elems_at_done = got_q.size();
    end
  end

  //////////////////////////////////////////////////
  // Random numbers and reference model
  //////////////////////////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic int unsigned rand_bits(input int nbits);
    int unsigned v;
    v = 0;
    for (int k = 0; k < nbits; k++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  // b(i;j) is the sum over g of L(g;j) * w(i;g) modulo 2^DATA_W
  function automatic dnc_value_t ref_b(input int n, input int i, input int j);
    longint unsigned acc;
    acc = 0;
    for (int g = 0; g < n; g++) begin
      acc = (acc + longint'(link_m[g][j]) * longint'(weight_m[i][g])) %
            (64'd1 << `DNC_DATA_W);
    end
    return dnc_value_t'(acc);
  endfunction

  task automatic fill_data(input int n, input int r, input int mode);
    for (int g = 0; g < n; g++) begin
      for (int j = 0; j < n; j++) begin
        if (mode == FILL_IDENT) begin
          link_m[g][j] = (g == j) ? dnc_value_t'(1) : dnc_value_t'(0);
        end else begin
          link_m[g][j] = dnc_value_t'(rand_bits(`DNC_DATA_W));
        end
      end
    end
    for (int i = 0; i < r; i++) begin
      for (int g = 0; g < n; g++) begin
        weight_m[i][g] = dnc_value_t'(rand_bits(`DNC_DATA_W));
        // All ones on the last head make every sum overflow
        if (mode == FILL_MAX && i == r - 1) begin
          weight_m[i][g] = '1;
        end
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic check_b_elem(input dnc_b_elem_t exp, input dnc_b_elem_t got,
                              input string what);
    n_checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s head %0d loc %0d value %h, expected head %0d loc %0d value %h",
               $time, what, got.head, got.loc, got.value, exp.head, exp.loc, exp.value);
    end
  endtask

  task automatic check_flag(input logic exp, input logic got, input string what);
    n_checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  task automatic apply_reset();
    RST = 1'b1;
    repeat (2) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
  endtask

  task automatic start_run(input int n, input int r);
    @(negedge CLK);
    size.size_n = dnc_idx_t'(n);
    size.size_r = dnc_idx_t'(r);
    start       = 1'b1;
    @(negedge CLK);
    start = 1'b0;
    check_flag(1'b1, busy, "busy after start");
  endtask

  // Ignored start leaves busy as it was
  task automatic try_start(input int n, input int r);
    logic busy_before;
    @(negedge CLK);
    busy_before = busy;
    size.size_n = dnc_idx_t'(n);
    size.size_r = dnc_idx_t'(r);
    start       = 1'b1;
    @(negedge CLK);
    start = 1'b0;
    check_flag(busy_before, busy, "busy after ignored start");
    @(negedge CLK);
    check_flag(busy_before, busy, "busy a cycle later");
  endtask

  // Strobes both inputs with random data
  task automatic drive_junk();
    w_in       = dnc_value_t'(rand_bits(`DNC_DATA_W));
    w_in_valid = 1'b1;
    l_in       = dnc_value_t'(rand_bits(`DNC_DATA_W));
    l_in_valid = 1'b1;
  endtask

  task automatic send_link(input int n, input bit noise);
    int cnt;
    cnt = 0;
    while (cnt < n * n) begin
      @(negedge CLK);
      l_in_valid = 1'b0;
      // Gap about one slot in four when noisy
      if (l_accept && (!noise || rand_bits(2) != 0)) begin
        l_in       = link_m[cnt / n][cnt % n];
        l_in_valid = 1'b1;
        cnt++;
      end
    end
  endtask

  task automatic send_weights(input int n, input int r, input bit noise);
    int cnt;
    for (int h = 0; h < r; h++) begin
      cnt = 0;
      while (cnt < n) begin
        @(negedge CLK);
        w_in_valid = 1'b0;
        l_in_valid = 1'b0;
        if (w_accept) begin
          if (!noise || rand_bits(2) != 0) begin
            w_in       = weight_m[h][cnt];
            w_in_valid = 1'b1;
            cnt++;
          end
        end else if (noise) begin
          drive_junk();
        end
      end
    end
  endtask

  task automatic wait_done(input bit noise);
    do begin
      @(negedge CLK);
      l_in_valid = 1'b0;
      w_in_valid = 1'b0;
      if (noise) begin
        drive_junk();
      end
    end while (!done);
    @(negedge CLK);
    l_in_valid = 1'b0;
    w_in_valid = 1'b0;
    check_flag(1'b0, busy, "busy after done");
    check_flag(1'b0, done, "done second cycle");
  endtask

  task automatic compare_results(input int n, input int r, input int done_before);
    dnc_b_elem_t exp;
    int          k;
    if (got_q.size() != n * r) begin
      errors++;
      $display("Wrong number of b elements: got %0d, expected %0d", got_q.size(), n * r);
    end
    if (n_done - done_before != 1) begin
      errors++;
      $display("done pulsed %0d times in one run instead of once", n_done - done_before);
    end else if (elems_at_done != n * r) begin
      errors++;
      $display("done came after %0d b elements instead of %0d", elems_at_done, n * r);
    end
    // Expected order is head first and then location
    for (int i = 0; i < r; i++) begin
      for (int j = 0; j < n; j++) begin
        k         = i * n + j;
        exp.value = ref_b(n, i, j);
        exp.head  = dnc_idx_t'(i);
        exp.loc   = dnc_idx_t'(j);
        if (k < got_q.size()) begin
          check_b_elem(exp, got_q[k], "b element");
        end
      end
    end
  endtask

  task automatic run_case(input int n, input int r, input int mode, input bit noise,
                          input bit poke_start);
    int done_before;
    fill_data(n, r, mode);
    got_q.delete();
    done_before = n_done;
    start_run(n, r);
    // Valid size while the DUT is already busy
    if (poke_start) begin
      try_start(2, 2);
    end
    send_link(n, noise);
    send_weights(n, r, noise);
    wait_done(noise);
    compare_results(n, r, done_before);
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic reset_levels();
    @(negedge CLK);
    check_flag(1'b0, busy, "busy after reset");
    check_flag(1'b0, done, "done after reset");
    check_flag(1'b0, l_accept, "l_accept after reset");
    check_flag(1'b0, w_accept, "w_accept after reset");
    check_flag(1'b0, b_out_valid, "b_out_valid after reset");
  endtask

  task automatic rejected_starts();
    int done_before;
    got_q.delete();
    done_before = n_done;
    try_start(0, 2);
    try_start(`DNC_MAX_N + 1, 2);
    try_start(2, 0);
    try_start(2, `DNC_MAX_R + 1);
    if (got_q.size() != 0 || n_done != done_before) begin
      errors++;
      $display("Rejected start still produced output or a done pulse");
    end
    run_case(3, 1, FILL_RAND, 1'b0, 1'b1);
  endtask

  initial begin
    errors        = 0;
    n_checks      = 0;
    n_done        = 0;
    elems_at_done = 0;
    lfsr          = LFSR_SEED;
    RST           = 1'b1;
    start         = 1'b0;
    size          = '0;
    l_in          = '0;
    l_in_valid    = 1'b0;
    w_in          = '0;
    w_in_valid    = 1'b0;

    apply_reset();
    reset_levels();
    // Identity link gives b equal to w
    run_case(4, 2, FILL_IDENT, 1'b0, 1'b0);
    run_case(5, 3, FILL_MAX, 1'b0, 1'b0);
    // Full size with gaps and ignored strobes
    run_case(`DNC_MAX_N, `DNC_MAX_R, FILL_RAND, 1'b1, 1'b0);
    rejected_starts();
    // Back to back runs with changing sizes
    run_case(3, 2, FILL_RAND, 1'b0, 1'b0);
    run_case(6, 1, FILL_RAND, 1'b0, 1'b0);

    $display("Checks: %0d  errors: %0d", n_checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/dnc_backward_weighting.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dnc_defines.svh"

module dnc_backward_weighting (
  input  wire                  CLK,
  input  wire                  RST,
  input  wire                  start,
  input  dnc_pkg::dnc_size_t   size,
  input  dnc_pkg::dnc_value_t  l_in,
  input  wire                  l_in_valid,
  input  dnc_pkg::dnc_value_t  w_in,
  input  wire                  w_in_valid,
  output logic                 busy,
  output logic                 done,
  output logic                 l_accept,
  output logic                 w_accept,
  output dnc_pkg::dnc_b_elem_t b_out,
  output logic                 b_out_valid
);

  import dnc_pkg::*;

  dnc_ctrl_e state;
  dnc_size_t size_q;
  dnc_idx_t  head;
  dnc_idx_t  w_cnt;

  logic        start_ok;
  logic        size_ok;
  logic        link_wr;
  logic        link_full;
  logic        weight_wr;
  logic        head_done;
  logic        b_valid;
  dnc_idx_t    rd_loc;
  dnc_idx_t    rd_step;
  dnc_value_t  rd_data;
  dnc_b_elem_t b_elem;

  //////////////////////////////////////////////////
  // Start check and handshake levels
  //////////////////////////////////////////////////

  // Zero or oversized dimensions are rejected
  assign size_ok = (size.size_n != '0) && (size.size_n <= `DNC_MAX_N) &&
                   (size.size_r != '0) && (size.size_r <= `DNC_MAX_R);

  // Only taken while idle
  assign start_ok = start && size_ok && (state == ctrl_idle);

  assign busy     = (state != ctrl_idle);
  assign done     = (state == ctrl_finish);
  // Drops as soon as the link store reports full
  assign l_accept = (state == ctrl_load_link) && !link_full;
  assign w_accept = (state == ctrl_load_weight);

  assign link_wr   = l_accept && l_in_valid;
  assign weight_wr = w_accept && w_in_valid;

  // Results go straight out
  assign b_out       = b_elem;
  assign b_out_valid = b_valid;

  //////////////////////////////////////////////////
  // Controller FSM
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state  <= ctrl_idle;
      size_q <= '0;
      head   <= '0;
      w_cnt  <= '0;
    end else begin
      case (state)
        ctrl_idle: begin
          if (start_ok) begin
            size_q <= size;
            head   <= '0;
            w_cnt  <= '0;
            state  <= ctrl_load_link;
          end
        end
        ctrl_load_link: begin
          if (link_full) begin
            state <= ctrl_load_weight;
          end
        end
        ctrl_load_weight: begin
          // One row of w per head
          if (weight_wr) begin
            if (w_cnt == size_q.size_n - 1'b1) begin
              w_cnt <= '0;
              state <= ctrl_compute;
            end else begin
              w_cnt <= w_cnt + 1'b1;
            end
          end
        end
        ctrl_compute: begin
          if (head_done) begin
            if (head == size_q.size_r - 1'b1) begin
              state <= ctrl_finish;
            end else begin
              head  <= head + 1'b1;
              state <= ctrl_load_weight;
            end
          end
        end
        ctrl_finish: begin
          state <= ctrl_idle;
        end
        default: begin
          state <= ctrl_idle;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////

  dnc_matrix_transpose u_transpose (
    .CLK       (CLK),
    .RST       (RST),
    .clear     (start_ok),
    .size_n    (size_q.size_n),
    .link_wr   (link_wr),
    .link_data (l_in),
    .rd_loc    (rd_loc),
    .rd_step   (rd_step),
    .link_full (link_full),
    .rd_data   (rd_data)
  );

  dnc_matrix_product u_product (
    .CLK         (CLK),
    .RST         (RST),
    .size_n      (size_q.size_n),
    .head        (head),
    .weight_wr   (weight_wr),
    .weight_data (w_in),
    .rd_data     (rd_data),
    .rd_loc      (rd_loc),
    .rd_step     (rd_step),
    .b_valid     (b_valid),
    .b_elem      (b_elem),
    .head_done   (head_done)
  );

endmodule

`default_nettype wire

// ==== verilog/dnc_defines.svh ====
`ifndef DNC_DEFINES_SVH
`define DNC_DEFINES_SVH

// Width of one element of L, w and b
`define DNC_DATA_W 16

// Largest number of memory locations
`define DNC_MAX_N 8

// Largest number of read heads
`define DNC_MAX_R 4

// Location, step and head index width
// Has to hold the value DNC_MAX_N itself for size checks
`define DNC_IDX_W 4

`endif

// ==== verilog/dnc_matrix_product.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dnc_defines.svh"

module dnc_matrix_product (
  input  wire                  CLK,
  input  wire                  RST,
  input  dnc_pkg::dnc_idx_t    size_n,
  input  dnc_pkg::dnc_idx_t    head,
  input  wire                  weight_wr,
  input  dnc_pkg::dnc_value_t  weight_data,
  input  dnc_pkg::dnc_value_t  rd_data,
  output dnc_pkg::dnc_idx_t    rd_loc,
  output dnc_pkg::dnc_idx_t    rd_step,
  output logic                 b_valid,
  output dnc_pkg::dnc_b_elem_t b_elem,
  output logic                 head_done
);

  import dnc_pkg::*;

  localparam int ADDR_W = $clog2(`DNC_MAX_N);

  //////////////////////////////////////////////////
  // Weighting vector of the current head
  //////////////////////////////////////////////////

  dnc_value_t w_mem [`DNC_MAX_N];
  dnc_idx_t   wr_cnt;
  dnc_idx_t   n_last;
  logic       w_last;

  assign n_last = size_n - 1'b1;
  assign w_last = weight_wr && (wr_cnt == n_last);

  always_ff @(posedge CLK) begin
    if (weight_wr) begin
      w_mem[wr_cnt[ADDR_W-1:0]] <= weight_data;
    end
  end

  //////////////////////////////////////////////////
  // Multiply-accumulate
  //////////////////////////////////////////////////

  logic       run;
  logic       mac_en;
  logic       step_last;
  dnc_value_t acc;
  dnc_value_t mac_prod;
  dnc_value_t acc_next;

  // The output cycle of a location carries no MAC
  assign mac_en    = run && !b_valid;
  assign step_last = (rd_step == n_last);

  // Both results wrap at the data width
  assign mac_prod = rd_data * w_mem[rd_step[ADDR_W-1:0]];
  assign acc_next = acc + mac_prod;

  // Sequencing of wr_cnt, location, step and flags
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_cnt    <= '0;
      run       <= 1'b0;
      rd_loc    <= '0;
      rd_step   <= '0;
      b_valid   <= 1'b0;
      head_done <= 1'b0;
    end else begin
      b_valid <= 1'b0;
      // Loading
      if (weight_wr) begin
        head_done <= 1'b0;
        if (w_last) begin
          // Full vector starts compute on the next cycle
          wr_cnt  <= '0;
          run     <= 1'b1;
          rd_loc  <= '0;
          rd_step <= '0;
        end else begin
          wr_cnt <= wr_cnt + 1'b1;
        end
      end
      // Stepping g for location j
      if (mac_en) begin
        if (step_last) begin
          rd_step <= '0;
          b_valid <= 1'b1;
          if (rd_loc == n_last) begin
            // Whole head emitted
            run       <= 1'b0;
            rd_loc    <= '0;
            head_done <= 1'b1;
          end else begin
            rd_loc <= rd_loc + 1'b1;
          end
        end else begin
          rd_step <= rd_step + 1'b1;
        end
      end
    end
  end

  // Accumulator and result element
  always_ff @(posedge CLK) begin
    if (w_last) begin
      acc <= '0;
    end else if (mac_en) begin
      if (step_last) begin
        acc          <= '0;
        b_elem.value <= acc_next;
        b_elem.head  <= head;
        b_elem.loc   <= rd_loc;
      end else begin
        acc <= acc_next;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/dnc_matrix_transpose.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dnc_defines.svh"

module dnc_matrix_transpose (
  input  wire                  CLK,
  input  wire                  RST,
  input  wire                  clear,
  input  dnc_pkg::dnc_idx_t    size_n,
  input  wire                  link_wr,
  input  dnc_pkg::dnc_value_t  link_data,
  input  dnc_pkg::dnc_idx_t    rd_loc,
  input  dnc_pkg::dnc_idx_t    rd_step,
  output logic                 link_full,
  output dnc_pkg::dnc_value_t  rd_data
);

  import dnc_pkg::*;

  // Address bits actually needed inside the array
  localparam int ADDR_W = $clog2(`DNC_MAX_N);

  //////////////////////////////////////////////////
  // Link matrix storage
  //////////////////////////////////////////////////

  // Indexed [row g][column j] in the order L arrives
  dnc_value_t link_mem [`DNC_MAX_N][`DNC_MAX_N];

  // Row-major write position
  dnc_idx_t wr_row;
  dnc_idx_t wr_col;
  dnc_idx_t n_last;
  logic     wr_en;

  assign n_last = size_n - 1'b1;

  // Extra writes after the matrix is full are dropped
  assign wr_en = link_wr && !link_full;

  always_ff @(posedge CLK) begin
    if (wr_en) begin
      link_mem[wr_row[ADDR_W-1:0]][wr_col[ADDR_W-1:0]] <= link_data;
    end
  end

  // Column counter wraps at N and the row advances on wrap
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_row    <= '0;
      wr_col    <= '0;
      link_full <= 1'b0;
    end else if (clear) begin
      // New run starts filling from L(0;0)
      wr_row    <= '0;
      wr_col    <= '0;
      link_full <= 1'b0;
    end else if (wr_en) begin
      if (wr_col == n_last) begin
        wr_col <= '0;
        if (wr_row == n_last) begin
          // Last element of the N x N block
          wr_row    <= '0;
          link_full <= 1'b1;
        end else begin
          wr_row <= wr_row + 1'b1;
        end
      end else begin
        wr_col <= wr_col + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Transposed read
  //////////////////////////////////////////////////

  // Step picks the row and location the column to read L(g;j) as L'(j;g)
  assign rd_data = link_mem[rd_step[ADDR_W-1:0]][rd_loc[ADDR_W-1:0]];

endmodule

`default_nettype wire

// ==== verilog/dnc_pkg.sv ====
`default_nettype none

`include "dnc_defines.svh"

package dnc_pkg;

  //////////////////////////////////////////////////
  // Element and index types
  //////////////////////////////////////////////////

  // One unsigned value whose arithmetic wraps at this width
  typedef logic [`DNC_DATA_W-1:0] dnc_value_t;

  // Location, step or head number
  typedef logic [`DNC_IDX_W-1:0] dnc_idx_t;

  // Problem size sampled with start
  typedef struct packed {
    dnc_idx_t size_n;
    dnc_idx_t size_r;
  } dnc_size_t;

  // One element of b tagged with where it belongs
  typedef struct packed {
    dnc_value_t value;
    dnc_idx_t   head;
    dnc_idx_t   loc;
  } dnc_b_elem_t;

  //////////////////////////////////////////////////
  // Controller states
  //////////////////////////////////////////////////

  typedef enum logic [2:0] {
    ctrl_idle,
    ctrl_load_link,
    ctrl_load_weight,
    ctrl_compute,
    ctrl_finish
  } dnc_ctrl_e;

endpackage

`default_nettype wire
